//--- rtl/mbu_pkg.sv
// Memory bank unit widths, bus and control structs, state and opcode enums, constants

package mbu_pkg;

   //////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////

   // Bank registers are one byte each and there are eight of them
   localparam int BANK_W    = 8;
   localparam int IDX_W     = 3;
   localparam int NUM_BANKS = 1 << IDX_W;

   // The I/O address bus is 8 bits wide, microcode address fields are 5
   localparam int ADR_W   = 8;
   localparam int UADDR_W = 5;

   typedef logic [BANK_W-1:0] bank_t;
   typedef logic [IDX_W-1:0]  bank_idx_t;

   //////////////////////////////////////////////////
   // Control unit request
   //////////////////////////////////////////////////

   // One microcode step as seen by the MBU. The ir field carries IR bits 2..0
   typedef struct packed {
      logic [UADDR_W-1:0] raddr;
      logic [UADDR_W-1:0] waddr;
      logic               ir_idx;
      bank_idx_t          ir;
   } cu_ctrl_t;

   // Decoded control unit operation, one per cycle
   typedef enum logic [1:0] {
      CU_NOP,
      CU_READ_MBP,
      CU_WRITE_MBP,
      CU_WRITE_AR
   } cu_op_e;

   // Microcode addresses the MBU answers to
   localparam logic [UADDR_W-1:0] RADDR_READ_MBP      = 5'b01101;
   localparam logic [UADDR_W-1:0] WADDR_WRITE_MBP_A   = 5'b01100;
   localparam logic [UADDR_W-1:0] WADDR_WRITE_MBP_B   = 5'b01101;
   // Only the top three bits matter, the low two pick the bank
   localparam logic [UADDR_W-1:0] WADDR_WRITE_AR_BASE = 5'b00100;

   //////////////////////////////////////////////////
   // I/O bus (Wishbone classic)
   //////////////////////////////////////////////////

   typedef struct packed {
      logic             cyc;
      logic             stb;
      logic             we;
      logic [ADR_W-1:0] adr;
      bank_t            dat_w;
   } wb_req_t;

   typedef struct packed {
      logic  ack;
      bank_t dat_r;
   } wb_rsp_t;

   typedef enum logic {
      WB_IDLE,
      WB_ACK
   } wb_state_e;

   //////////////////////////////////////////////////
   // Fixed values
   //////////////////////////////////////////////////

   // Seen on every read port while the unit is still disabled
   localparam bank_t DEFAULT_ROM = 8'h80;
   localparam bank_t DEFAULT_RAM = 8'h00;

   // MBP is register 0, used for fetches and by write_mbp
   localparam bank_idx_t MBP_IDX = 3'd0;

   // Start of the 8-location I/O window unless the top level overrides it
   localparam logic [ADR_W-1:0] IO_BASE_DEFAULT = 8'h08;

endpackage

//--- rtl/mbu_cu_decode.sv
// Microcode address decoder, auto-index flag and aext register select

`timescale 1ns/1ps

module mbu_cu_decode (
   input  logic               clk,
   input  logic               rst_n,
   input  mbu_pkg::cu_ctrl_t  cu,
   output logic               mbp_wr,
   output mbu_pkg::bank_idx_t rd_sel,
   output logic               ibus_oe
);

   import mbu_pkg::*;

   logic   is_rmbp;
   logic   is_wmbp;
   logic   is_war;
   logic   idx_q;
   cu_op_e op;

   //////////////////////////////////////////////////
   // Address decoding
   //////////////////////////////////////////////////

   // read_mbp sits on a single read address
   assign is_rmbp = (cu.raddr == RADDR_READ_MBP);

   // write_mbp has two write addresses, the plain one and the one with flags
   assign is_wmbp = (cu.waddr == WADDR_WRITE_MBP_A) ||
                    (cu.waddr == WADDR_WRITE_MBP_B);

   // write_ar covers four write addresses, one per bank selector value
   assign is_war = (cu.waddr[UADDR_W-1:2] == WADDR_WRITE_AR_BASE[UADDR_W-1:2]);

   // A write of MBP wins over everything, then the read, then AR indexing.
   // The two write decodes cannot both hit since they share waddr
   always_comb begin
      if (is_wmbp) begin
         op = CU_WRITE_MBP;
      end else if (is_rmbp) begin
         op = CU_READ_MBP;
      end else if (is_war) begin
         op = CU_WRITE_AR;
      end else begin
         op = CU_NOP;
      end
   end

   //////////////////////////////////////////////////
   // Auto-index flag
   //////////////////////////////////////////////////

   // The control unit raises ir_idx one step ahead of the write_ar that
   // should use IR. The flag is reloaded every cycle, so it lives for
   // exactly one cycle after the edge that sampled it
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         idx_q <= 1'b0;
      end else begin
         idx_q <= cu.ir_idx;
      end
   end

   //////////////////////////////////////////////////
   // Read addressing
   //////////////////////////////////////////////////

   // Bank shown on aext for each operation
   //   read_mbp       MBP, also driven onto the internal bus
   //   write_ar 00    MBP
   //   write_ar 01    MBD
   //   write_ar 10    MBS
   //   write_ar 11    register 3, or IR[2:0] when auto-indexing
   //   anything else  MBP so instruction fetches use the program bank
   always_comb begin
      case (op)
         CU_READ_MBP: begin
            rd_sel = MBP_IDX;
         end
         CU_WRITE_AR: begin
            if ((cu.waddr[1:0] == 2'b11) && idx_q) begin
               rd_sel = cu.ir;
            end else begin
               rd_sel = {1'b0, cu.waddr[1:0]};
            end
         end
         default: begin
            rd_sel = MBP_IDX;
         end
      endcase
   end

   // Write of MBP from the internal bus happens at the next rising edge
   assign mbp_wr = (op == CU_WRITE_MBP);

   // The MBU only drives the internal bus during read_mbp
   assign ibus_oe = (op == CU_READ_MBP);

endmodule

//--- rtl/mbu_regfile.sv
// Bank register file with enable flag, power-on default and two read ports

`timescale 1ns/1ps

module mbu_regfile (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               fp_ram_rom,
   input  logic               mbp_wr,
   input  logic               io_wr,
   input  mbu_pkg::bank_t     ibus_in,
   input  mbu_pkg::bank_t     io_wdata,
   input  mbu_pkg::bank_idx_t rd_sel,
   input  mbu_pkg::bank_idx_t io_idx,
   output mbu_pkg::bank_t     aext,
   output mbu_pkg::bank_t     io_rdata
);

   import mbu_pkg::*;

   bank_t regs [NUM_BANKS];
   logic  enabled;
   bank_t default_val;

   //////////////////////////////////////////////////
   // Register storage
   //////////////////////////////////////////////////

   // Two writers share the file. The control unit only ever writes MBP,
   // the I/O side can write any of the eight registers. The bus slave
   // holds off while mbp_wr is high, so both never land on the same edge
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < NUM_BANKS; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (mbp_wr) begin
            regs[MBP_IDX] <= ibus_in;
         end
         if (io_wr) begin
            regs[io_idx] <= io_wdata;
         end
      end
   end

   //////////////////////////////////////////////////
   // Power-on defaults
   //////////////////////////////////////////////////

   // The unit comes up disabled and stays so until a program writes any
   // bank register through the I/O window. Control unit writes of MBP do
   // not count, since a ROM bootstrap may run before the OS sets up banks
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         enabled <= 1'b0;
      end else if (io_wr) begin
         enabled <= 1'b1;
      end
   end

   // While disabled the high byte of the address comes from the front
   // panel switch. ROM sits at bank 80 and RAM at bank 00
   assign default_val = fp_ram_rom ? DEFAULT_ROM : DEFAULT_RAM;

   //////////////////////////////////////////////////
   // Read ports
   //////////////////////////////////////////////////

   // Extended address output, selected by the control unit decoder.
   // It is purely combinational so a write shows up one cycle later
   always_comb begin
      if (enabled) begin
         aext = regs[rd_sel];
      end else begin
         aext = default_val;
      end
   end

   // I/O read port used by the bus slave for IN instructions
   always_comb begin
      if (enabled) begin
         io_rdata = regs[io_idx];
      end else begin
         io_rdata = default_val;
      end
   end

endmodule

//--- rtl/mbu_wb_slave.sv
// Wishbone classic slave for the bank register I/O window

`timescale 1ns/1ps

module mbu_wb_slave #(
   parameter logic [mbu_pkg::ADR_W-1:0] IO_BASE = mbu_pkg::IO_BASE_DEFAULT
) (
   input  logic               clk,
   input  logic               rst_n,
   input  mbu_pkg::wb_req_t   wb_req,
   output mbu_pkg::wb_rsp_t   wb_rsp,
   input  logic               mbp_wr,
   output logic               io_wr,
   output mbu_pkg::bank_idx_t io_idx,
   output mbu_pkg::bank_t     io_wdata,
   input  mbu_pkg::bank_t     io_rdata
);

   import mbu_pkg::*;

   wb_state_e state_q;
   wb_state_e state_d;
   logic      req_valid;
   logic      in_win;
   logic      accept;
   bank_t     rd_data_q;

   // The window is eight locations long and IO_BASE is expected to be
   // aligned to eight, so the upper address bits alone pick it out
   assign in_win    = (wb_req.adr[ADR_W-1:IDX_W] == IO_BASE[ADR_W-1:IDX_W]);
   assign req_valid = wb_req.cyc && wb_req.stb;

   // Register index and write data come straight from the bus
   assign io_idx   = wb_req.adr[IDX_W-1:0];
   assign io_wdata = wb_req.dat_w;

   //////////////////////////////////////////////////
   // Handshake FSM
   //////////////////////////////////////////////////

   // A request is taken from WB_IDLE unless the control unit writes MBP
   // in the same cycle. Then we simply wait and look again next edge
   always_comb begin
      state_d = state_q;
      accept  = 1'b0;
      case (state_q)
         WB_IDLE: begin
            if (req_valid && !mbp_wr) begin
               accept  = 1'b1;
               state_d = WB_ACK;
            end
         end
         // ack is up for one cycle, the master drops stb right after
         WB_ACK: begin
            state_d = WB_IDLE;
         end
         default: begin
            state_d = WB_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= WB_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Writes commit on the accepting edge. Out-of-window writes are acked
   // but dropped
   assign io_wr = accept && wb_req.we && in_win;

   // Read data is captured when the request is taken, zero outside the window
   always_ff @(posedge clk) begin
      if (accept) begin
         rd_data_q <= in_win ? io_rdata : '0;
      end
   end

   always_comb begin
      wb_rsp.ack   = (state_q == WB_ACK);
      wb_rsp.dat_r = rd_data_q;
   end

endmodule

//--- rtl/mbu_top.sv
// Memory bank unit top level with decoder, register file and I/O bus slave

`timescale 1ns/1ps

module mbu_top #(
   parameter logic [mbu_pkg::ADR_W-1:0] IO_BASE = mbu_pkg::IO_BASE_DEFAULT
) (
   input  logic              clk,
   input  logic              rst_n,
   // Control unit side
   input  mbu_pkg::cu_ctrl_t cu,
   input  mbu_pkg::bank_t    ibus_in,
   output mbu_pkg::bank_t    ibus_out,
   output logic              ibus_oe,
   // Front panel RAM/ROM switch, high selects ROM
   input  logic              fp_ram_rom,
   // I/O bus
   input  mbu_pkg::wb_req_t  wb_req,
   output mbu_pkg::wb_rsp_t  wb_rsp,
   // Extended address above the 16-bit CPU address
   output mbu_pkg::bank_t    aext
);

   import mbu_pkg::*;

   logic      mbp_wr;
   bank_idx_t rd_sel;
   logic      io_wr;
   bank_idx_t io_idx;
   bank_t     io_wdata;
   bank_t     io_rdata;

   //////////////////////////////////////////////////
   // Decoding and read addressing
   //////////////////////////////////////////////////

   mbu_cu_decode mbu_cu_decode_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .cu      (cu),
      .mbp_wr  (mbp_wr),
      .rd_sel  (rd_sel),
      .ibus_oe (ibus_oe)
   );

   //////////////////////////////////////////////////
   // Register file
   //////////////////////////////////////////////////

   mbu_regfile mbu_regfile_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .fp_ram_rom (fp_ram_rom),
      .mbp_wr     (mbp_wr),
      .io_wr      (io_wr),
      .ibus_in    (ibus_in),
      .io_wdata   (io_wdata),
      .rd_sel     (rd_sel),
      .io_idx     (io_idx),
      .aext       (aext),
      .io_rdata   (io_rdata)
   );

   //////////////////////////////////////////////////
   // I/O bus interface
   //////////////////////////////////////////////////

   mbu_wb_slave #(
      .IO_BASE (IO_BASE)
   ) mbu_wb_slave_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .wb_req   (wb_req),
      .wb_rsp   (wb_rsp),
      .mbp_wr   (mbp_wr),
      .io_wr    (io_wr),
      .io_idx   (io_idx),
      .io_wdata (io_wdata),
      .io_rdata (io_rdata)
   );

   // The internal bus carries the same byte as aext, qualified by ibus_oe
   assign ibus_out = aext;

endmodule

//--- tb/mbu_clkgen.sv
// Testbench clock source and power-on reset generator

`timescale 1ns/1ps

module mbu_clkgen #(
   parameter int PERIOD_NS    = 20,
   parameter int RESET_CYCLES = 3
) (
   output logic clk,
   output logic rst_n
);

   // Free-running clock, low for the first half period
   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // Reset is let go on a falling edge, half a period away from the sampling edge
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

//--- tb/mbu_sva.sv
// Bound assertions on the I/O bus handshake, the bus output enable and write arbitration

`timescale 1ns/1ps

module mbu_sva (
   input logic             clk,
   input logic             rst_n,
   input mbu_pkg::wb_req_t wb_req,
   input mbu_pkg::wb_rsp_t wb_rsp,
   input logic             ibus_oe,
   input logic             mbp_wr
);

   // Count of failed assertions, looked at by the testbench at the end
   int fail_count = 0;

   // ack is a single-cycle pulse
   ack_single: assert property (@(posedge clk) disable iff (!rst_n)
      wb_rsp.ack |=> !wb_rsp.ack)
      else begin
         fail_count++;
         $error("ack stayed high for more than one cycle");
      end

   // The slave only answers a live request
   ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
      else begin
         fail_count++;
         $error("ack seen without cyc and stb");
      end

   // The MBU is off the internal bus when reset ends
   oe_low_at_reset: assert property (@(posedge clk)
      $rose(rst_n) |-> !ibus_oe)
      else begin
         fail_count++;
         $error("ibus_oe high right after reset");
      end

   // A waiting bus write is not taken on an edge where the control unit writes MBP
   no_write_clash: assert property (@(posedge clk) disable iff (!rst_n)
      (mbp_wr && wb_req.cyc && wb_req.stb && wb_req.we && !wb_rsp.ack)
      |=> !wb_rsp.ack)
      else begin
         fail_count++;
         $error("bus write accepted on the same edge as mbp_wr");
      end

endmodule

bind mbu_top mbu_sva mbu_sva_i (
   .clk     (clk),
   .rst_n   (rst_n),
   .wb_req  (wb_req),
   .wb_rsp  (wb_rsp),
   .ibus_oe (ibus_oe),
   .mbp_wr  (mbp_wr)
);

//--- tb/mbu_tb.sv
// Testbench top for the memory bank unit: test file records, random bus pairs, checks

`timescale 1ns/1ps

module mbu_tb;

   import mbu_pkg::*;

   localparam logic [ADR_W-1:0] IO_BASE     = 8'h08;
   localparam int               ACK_TIMEOUT = 20;
   localparam int               RST_TIMEOUT = 10;
   localparam int               SETTLE      = 1;
   localparam int               RAND_PAIRS  = 20;
   localparam logic [31:0]      SEED        = 32'd42466;
   localparam int               EOF_CHAR    = -1;

   logic      clk;
   logic      rst_n;
   cu_ctrl_t  cu;
   bank_t     ibus_in;
   bank_t     ibus_out;
   logic      ibus_oe;
   logic      fp_ram_rom;
   wb_req_t   wb_req;
   wb_rsp_t   wb_rsp;
   bank_t     aext;

   mbu_clkgen mbu_clkgen_i (
      .clk   (clk),
      .rst_n (rst_n)
   );

   mbu_top #(
      .IO_BASE (IO_BASE)
   ) mbu_top_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .cu         (cu),
      .ibus_in    (ibus_in),
      .ibus_out   (ibus_out),
      .ibus_oe    (ibus_oe),
      .fp_ram_rom (fp_ram_rom),
      .wb_req     (wb_req),
      .wb_rsp     (wb_rsp),
      .aext       (aext)
   );

   //////////////////////////////////////////////////
   // Reporting and checks
   //////////////////////////////////////////////////

   task automatic stop_run(input string msg);
      $display("%s", msg);
      $display("TEST FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_bank(input string name, input bank_t got, input bank_t exp);
      if (got !== exp) begin
         stop_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_run($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
      end
   endtask

   task automatic expect_fields(input int got, input int want);
      if (got != want) begin
         stop_run("A record in the tests file has the wrong number of fields");
      end
   endtask

   // 32-bit xorshift with the 13/17/5 shift triple
   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   //////////////////////////////////////////////////
   // Bus master
   //////////////////////////////////////////////////

   // Called on a falling edge. Holds the request until ack, then keeps stb
   // up over the edge that ends the ack cycle, as a classic master does
   task automatic bus_access(input logic we, input logic [ADR_W-1:0] adr,
                             input bank_t wdat, output bank_t rdat);
      int cycles;
      wb_req.cyc   = 1'b1;
      wb_req.stb   = 1'b1;
      wb_req.we    = we;
      wb_req.adr   = adr;
      wb_req.dat_w = wdat;
      cycles = 0;
      @(negedge clk);
      // A colliding write_mbp only lasts one cycle
      cu = '0;
      while (!wb_rsp.ack && cycles < ACK_TIMEOUT) begin
         cycles++;
         @(negedge clk);
      end
      if (!wb_rsp.ack) begin
         stop_run("The bus slave gave no ack within 20 cycles");
      end else begin
         rdat = wb_rsp.dat_r;
         @(negedge clk);
         wb_req = '0;
      end
   endtask

   //////////////////////////////////////////////////
   // Test file records
   //////////////////////////////////////////////////

   task automatic skip_line(input int fd);
      int ch;
      ch = $fgetc(fd);
      while (ch != 10 && ch != EOF_CHAR) begin
         ch = $fgetc(fd);
      end
   endtask

   task automatic run_record(input int fd, input byte kind);
      logic [31:0] f [7];
      int          n;
      bank_t       rdat;
      case (kind)
         "S": begin
            n = $fscanf(fd, "%h %h", f[0], f[1]);
            expect_fields(n, 2);
            @(negedge clk);
            cu = '0;
            fp_ram_rom = f[0][0];
            #SETTLE;
            check_bank("aext", aext, f[1][7:0]);
         end
         "W": begin
            n = $fscanf(fd, "%h %h", f[0], f[1]);
            expect_fields(n, 2);
            @(negedge clk);
            cu = '0;
            bus_access(1'b1, f[0][7:0], f[1][7:0], rdat);
         end
         "R": begin
            n = $fscanf(fd, "%h %h", f[0], f[1]);
            expect_fields(n, 2);
            @(negedge clk);
            cu = '0;
            bus_access(1'b0, f[0][7:0], 8'h00, rdat);
            check_bank("dat_r", rdat, f[1][7:0]);
         end
         "C": begin
            n = $fscanf(fd, "%h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
            expect_fields(n, 7);
            @(negedge clk);
            cu.raddr  = f[0][4:0];
            cu.waddr  = f[1][4:0];
            cu.ir_idx = f[2][0];
            cu.ir     = f[3][2:0];
            ibus_in   = f[4][7:0];
            #SETTLE;
            check_bank("aext", aext, f[5][7:0]);
            check_flag("ibus_oe", ibus_oe, f[6][0]);
            if (f[6][0]) begin
               check_bank("ibus_out", ibus_out, f[5][7:0]);
            end
         end
         "X": begin
            n = $fscanf(fd, "%h %h %h %h", f[0], f[1], f[2], f[3]);
            expect_fields(n, 4);
            @(negedge clk);
            // write_mbp and the bus write start in the same cycle
            cu       = '0;
            cu.waddr = WADDR_WRITE_MBP_A;
            ibus_in  = f[2][7:0];
            bus_access(1'b1, f[0][7:0], f[1][7:0], rdat);
            #SETTLE;
            check_bank("aext", aext, f[3][7:0]);
         end
         default: begin
            stop_run("The tests file holds a record of unknown kind");
         end
      endcase
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial begin
      int          fd;
      int          ch;
      int          cycles;
      logic [31:0] rnd;
      bank_idx_t   idx;
      bank_t       val;
      bank_t       rdat;
      cu         = '0;
      ibus_in    = '0;
      fp_ram_rom = 1'b1;
      wb_req     = '0;
      fd = $fopen("tb/mbu_tests.txt", "r");
      if (fd == 0) begin
         stop_run("Could not open tb/mbu_tests.txt");
      end
      cycles = 0;
      while (rst_n !== 1'b1 && cycles < RST_TIMEOUT) begin
         cycles++;
         @(negedge clk);
      end
      if (rst_n !== 1'b1) begin
         stop_run("Reset was never released");
      end
      // Records start with a kind letter, a hash starts a comment
      ch = $fgetc(fd);
      while (ch != EOF_CHAR) begin
         if (ch == "#") begin
            skip_line(fd);
         end else if (ch != " " && ch != 10 && ch != 13 && ch != 9) begin
            run_record(fd, byte'(ch));
         end
         ch = $fgetc(fd);
      end
      $fclose(fd);
      // Write then read back at random locations of the window
      rnd = SEED;
      for (int i = 0; i < RAND_PAIRS; i++) begin
         rnd = next_random(rnd);
         idx = rnd[2:0];
         val = rnd[15:8];
         @(negedge clk);
         bus_access(1'b1, IO_BASE + {5'b0, idx}, val, rdat);
         @(negedge clk);
         bus_access(1'b0, IO_BASE + {5'b0, idx}, 8'h00, rdat);
         check_bank("dat_r", rdat, val);
         // The same low address bits outside the window read as zero
         @(negedge clk);
         bus_access(1'b0, IO_BASE + 8'h10 + {5'b0, idx}, 8'h00, rdat);
         check_bank("dat_r", rdat, 8'h00);
      end
      if (mbu_top_i.mbu_sva_i.fail_count == 0) begin
         $display("TEST OK");
         $finish;
      end else begin
         stop_run("One or more bound assertions failed during the run");
      end
   end

endmodule

//--- tb/mbu_tests.txt
# S sw aext | W adr data | R adr dat_r | X adr bus_data ibus_in final_reg0 (all hex)
# C raddr waddr ir_idx ir ibus_in aext ibus_oe, one control unit cycle
# Disabled after reset, switch picks ROM or RAM bank
S 1 80
R 08 80
R 0b 80
C 0d 00 0 0 00 80 1
S 0 00
R 0f 00
C 0d 00 0 0 00 00 1
R 21 00
# First bus write enables the unit
W 0a 5a
R 0a 5a
R 09 00
R 20 00
S 1 00
W 09 3c
R 09 3c
# write_mbp, then read_mbp, both write addresses
C 00 0c 0 0 a7 00 0
C 00 00 0 0 00 a7 0
C 0d 0d 0 0 b8 a7 0
C 0d 00 0 0 00 b8 1
# write_ar bank select and IR auto-indexing
C 00 04 0 0 00 b8 0
C 00 05 0 0 00 3c 0
C 00 06 0 0 00 5a 0
W 0b 71
W 0d e2
C 00 07 0 5 00 71 0
C 00 00 1 0 00 b8 0
C 00 07 0 5 00 e2 0
C 00 07 0 5 00 71 0
# Collision of bus write and write_mbp on register 0
X 08 c4 19 c4
R 08 c4
C 00 00 1 0 00 c4 0
C 00 05 0 5 00 3c 0

//--- tb.f
rtl/mbu_pkg.sv
rtl/mbu_cu_decode.sv
rtl/mbu_regfile.sv
rtl/mbu_wb_slave.sv
rtl/mbu_top.sv
tb/mbu_clkgen.sv
tb/mbu_sva.sv
tb/mbu_tb.sv

//--- Makefile
# Verilator build and run for the memory bank unit testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := mbu_tb
FILELIST  := tb.f
OBJ_DIR   := obj_dir

SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
